// File: common/id_pkg.sv
// Word types, opcode values and ALU function codes for the decode stage
// Every design unit pulls these in with a wildcard import
package id_pkg;

	// Data path words
	typedef logic [15:0] word_t;
	typedef logic [15:0] instr_t;

	// Instruction fields
	typedef logic [3:0] reg_addr_t;
	typedef logic [2:0] alu_func_t;
	typedef logic [3:0] shamt_t;
	typedef logic [7:0] imm8_t;

	// ALU group, func is the low opcode bits
	localparam logic [3:0] OP_ADD = 4'h0;
	localparam logic [3:0] OP_SUB = 4'h1;
	localparam logic [3:0] OP_AND = 4'h2;
	localparam logic [3:0] OP_NOR = 4'h3;

	// Shift group, 7 is left as a nop
	localparam logic [3:0] OP_SLL = 4'h4;
	localparam logic [3:0] OP_SRL = 4'h5;
	localparam logic [3:0] OP_SRA = 4'h6;

	// Memory and immediate loads
	localparam logic [3:0] OP_LW  = 4'h8;
	localparam logic [3:0] OP_SW  = 4'h9;
	localparam logic [3:0] OP_LHB = 4'hA;
	localparam logic [3:0] OP_LLB = 4'hB;

	// Control flow
	localparam logic [3:0] OP_BR  = 4'hC;
	localparam logic [3:0] OP_JAL = 4'hD;
	localparam logic [3:0] OP_JR  = 4'hE;
	localparam logic [3:0] OP_HLT = 4'hF;

	// Address calculation for lw and sw
	localparam alu_func_t FN_ADD = 3'd0;

	// jal drops its return address here
	localparam reg_addr_t LINK_REG = 4'd15;

endpackage

// File: common/dec_if.sv
// Decoded control fields of the live instruction
// The decoder drives every signal, the output register samples them
interface dec_if
	import id_pkg::*;
();

	// Entry is live this cycle
	logic valid;

	// Destination and write-back controls
	reg_addr_t dst_addr;
	logic we_rf;
	logic we_mem;
	logic re_mem;
	logic wb_sel;

	// ALU side fields
	logic src1sel;
	shamt_t shamt;
	alu_func_t func;
	imm8_t imm8;

	// Flow control
	logic hlt;
	logic jal;
	logic jr;
	logic [11:0] jal_off;
	word_t pc;

	modport dec (output valid, dst_addr, we_rf, we_mem, re_mem, wb_sel,
		src1sel, shamt, func, imm8, hlt, jal, jr, jal_off, pc);
	modport out (input valid, dst_addr, we_rf, we_mem, re_mem, wb_sel,
		src1sel, shamt, func, imm8, hlt, jal, jr, jal_off, pc);

endinterface

// File: common/rd_if.sv
// Two register read ports between the decoder and the register file
interface rd_if
	import id_pkg::*;
();

	// Requests from the decoder
	reg_addr_t addr0;
	logic re0;
	reg_addr_t addr1;
	logic re1;

	// Read data, also watched by the output register
	word_t data0;
	word_t data1;

	modport req (output addr0, re0, addr1, re1, input data0, data1);
	modport port (input addr0, re0, addr1, re1, output data0, data1);

endinterface

// File: hw/instr_latch.sv
// Holds the strobed instruction and pc for its decode cycle
// Kills the fetch that follows a jump so it never reaches the output
module instr_latch
	import id_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   in_valid,
	input  instr_t instr,
	input  word_t  pc,
	// Entry now leaving was a live jal or jr
	input  logic   jump,
	output logic   live,
	output instr_t lat_instr,
	output word_t  lat_pc
);

	// Live flag, a missing strobe or a jump ahead clears it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			live <= 1'b0;
		end else begin
			live <= in_valid & ~jump;
		end
	end

	// Payload only moves on a strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			lat_instr <= instr;
			lat_pc <= pc;
		end
	end

endmodule

// File: hw/decode/instr_decode.sv
// Opcode decoder for the live latch entry
// Drives the read port requests and the control fields, all enables gated by live
module instr_decode
	import id_pkg::*;
(
	input  logic   live,
	input  instr_t lat_instr,
	input  word_t  lat_pc,
	output logic   jump,
	rd_if.req      rd,
	dec_if.dec     dec
);

	logic [3:0] opcode;
	reg_addr_t f_rd;
	reg_addr_t f_rs;
	reg_addr_t f_rt;

	// Fixed field positions
	assign opcode = lat_instr[15:12];
	assign f_rd = lat_instr[11:8];
	assign f_rs = lat_instr[7:4];
	assign f_rt = lat_instr[3:0];

	// Raw fields pass straight through
	assign dec.valid = live;
	assign dec.shamt = lat_instr[3:0];
	assign dec.imm8 = lat_instr[7:0];
	assign dec.jal_off = lat_instr[11:0];
	assign dec.pc = lat_pc;

	always_comb begin
		// Defaults: nothing read, nothing written
		rd.addr0 = f_rs;
		rd.addr1 = f_rt;
		rd.re0 = 1'b0;
		rd.re1 = 1'b0;
		dec.dst_addr = f_rd;
		dec.func = opcode[2:0];
		dec.we_rf = 1'b0;
		dec.we_mem = 1'b0;
		dec.re_mem = 1'b0;
		dec.wb_sel = 1'b0;
		dec.src1sel = 1'b0;
		dec.hlt = 1'b0;
		dec.jal = 1'b0;
		dec.jr = 1'b0;
		if (live) begin
			case (opcode)
				OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
					rd.re0 = 1'b1;
					rd.re1 = 1'b1;
					dec.we_rf = 1'b1;
				end
				OP_SLL, OP_SRL, OP_SRA: begin
					// Second source is the shift amount
					rd.re0 = 1'b1;
					dec.src1sel = 1'b1;
					dec.we_rf = 1'b1;
				end
				OP_LW: begin
					rd.re0 = 1'b1;
					dec.func = FN_ADD;
					dec.re_mem = 1'b1;
					dec.wb_sel = 1'b1;
					dec.we_rf = 1'b1;
				end
				OP_SW: begin
					// Store data comes from rd on port 1
					rd.re0 = 1'b1;
					rd.re1 = 1'b1;
					rd.addr1 = f_rd;
					dec.func = FN_ADD;
					dec.we_mem = 1'b1;
				end
				OP_LHB: begin
					// Low byte of rd is kept
					rd.re0 = 1'b1;
					rd.addr0 = f_rd;
					dec.we_rf = 1'b1;
				end
				OP_LLB: dec.we_rf = 1'b1;
				OP_BR: begin
					// Condition and offset only, resolved later
				end
				OP_JAL: begin
					// R15 gets written here by the link port
					dec.dst_addr = LINK_REG;
					dec.jal = 1'b1;
				end
				OP_JR: begin
					rd.re0 = 1'b1;
					dec.jr = 1'b1;
				end
				OP_HLT: dec.hlt = 1'b1;
				default: begin
					// Opcode 7 is a nop
				end
			endcase
		end
	end

	// Tells the latch to squash the next fetch
	assign jump = dec.jal | dec.jr;

endmodule

// File: hw/decode/reg_file.sv
// Sixteen-entry register file with two read ports
// R0 reads zero, jal link write beats write-back, same-cycle writes bypass to reads
module reg_file
	import id_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	rd_if.port        rd,
	// Write-back port
	input  logic      wb_we,
	input  reg_addr_t wb_addr,
	input  word_t     wb_data,
	// Link port, always R15
	input  logic      link_we,
	input  word_t     link_data
);

	word_t regs [16];

	// Link assignment comes last so it wins on R15
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wb_we) begin
				regs[wb_addr] <= wb_data;
			end
			if (link_we) begin
				regs[LINK_REG] <= link_data;
			end
		end
	end

	// One read port with bypass in the same priority as the write
	function automatic word_t read_port(input reg_addr_t addr, input logic re);
		word_t val;
		if (!re || addr == '0) begin
			val = '0;
		end else if (link_we && addr == LINK_REG) begin
			val = link_data;
		end else if (wb_we && addr == wb_addr) begin
			val = wb_data;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_comb begin
		rd.data0 = read_port(rd.addr0, rd.re0);
		rd.data1 = read_port(rd.addr1, rd.re1);
	end

endmodule

// File: hw/id_out_reg.sv
// Output register of the decode stage
// Resolves jal and jr targets, issues the link write and registers the results
module id_out_reg
	import id_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	dec_if.out        dec,
	rd_if.port        rd,
	output logic      link_we,
	output word_t     link_data,
	output logic      out_valid,
	output word_t     p0,
	output word_t     p1,
	output shamt_t    shamt,
	output alu_func_t func,
	output imm8_t     imm8,
	output reg_addr_t dst_addr,
	output logic      src1sel,
	output logic      we_rf,
	output logic      we_mem,
	output logic      re_mem,
	output logic      wb_sel,
	output logic      hlt,
	output logic      j_ctrl,
	output word_t     j_pc
);

	word_t next_pc;
	word_t jal_tgt;
	word_t jmp_pc;

	// Return address and pc relative target
	assign next_pc = dec.pc + 16'd1;
	assign jal_tgt = next_pc + {{4{dec.jal_off[11]}}, dec.jal_off};

	// Zero target unless this is a jump
	assign jmp_pc = dec.jal ? jal_tgt : (dec.jr ? rd.data0 : '0);

	// R15 is written at the same edge the results are captured
	assign link_we = dec.jal;
	assign link_data = next_pc;

	// Control outputs
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			j_ctrl <= 1'b0;
			hlt <= 1'b0;
			we_rf <= 1'b0;
			we_mem <= 1'b0;
			re_mem <= 1'b0;
		end else begin
			out_valid <= dec.valid;
			j_ctrl <= dec.jal | dec.jr;
			hlt <= dec.hlt;
			we_rf <= dec.we_rf;
			we_mem <= dec.we_mem;
			re_mem <= dec.re_mem;
		end
	end

	// Operands and fields, held between live entries
	always_ff @(posedge clk) begin
		if (dec.valid) begin
			p0 <= rd.data0;
			p1 <= rd.data1;
			shamt <= dec.shamt;
			func <= dec.func;
			imm8 <= dec.imm8;
			dst_addr <= dec.dst_addr;
			src1sel <= dec.src1sel;
			wb_sel <= dec.wb_sel;
			j_pc <= jmp_pc;
		end
	end

endmodule

// File: hw/id_stage_top.sv
// Instruction decode stage of the 16-bit load/store core
// Strobe an instruction on in_valid, results appear on out_valid one cycle later
module id_stage_top
	import id_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	// Fetch side
	input  logic      in_valid,
	input  instr_t    instr,
	input  word_t     pc,
	// Write-back from the later stages
	input  logic      wb_we,
	input  reg_addr_t wb_addr,
	input  word_t     wb_data,
	// Decoded results
	output logic      out_valid,
	output word_t     p0,
	output word_t     p1,
	output shamt_t    shamt,
	output alu_func_t func,
	output imm8_t     imm8,
	output reg_addr_t dst_addr,
	output logic      src1sel,
	output logic      we_rf,
	output logic      we_mem,
	output logic      re_mem,
	output logic      wb_sel,
	output logic      hlt,
	output logic      j_ctrl,
	output word_t     j_pc
);

	logic live;
	instr_t lat_instr;
	word_t lat_pc;
	logic jump;

	// Link write from a jal
	logic link_we;
	word_t link_data;

	dec_if dec_bus ();
	rd_if rd_bus ();

	instr_latch u_latch (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.instr     (instr),
		.pc        (pc),
		.jump      (jump),
		.live      (live),
		.lat_instr (lat_instr),
		.lat_pc    (lat_pc)
	);

	instr_decode u_decode (
		.live      (live),
		.lat_instr (lat_instr),
		.lat_pc    (lat_pc),
		.jump      (jump),
		.rd        (rd_bus.req),
		.dec       (dec_bus.dec)
	);

	reg_file u_rf (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd        (rd_bus.port),
		.wb_we     (wb_we),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.link_we   (link_we),
		.link_data (link_data)
	);

	id_out_reg u_out (
		.clk       (clk),
		.arst_n    (arst_n),
		.dec       (dec_bus.out),
		.rd        (rd_bus.port),
		.link_we   (link_we),
		.link_data (link_data),
		.out_valid (out_valid),
		.p0        (p0),
		.p1        (p1),
		.shamt     (shamt),
		.func      (func),
		.imm8      (imm8),
		.dst_addr  (dst_addr),
		.src1sel   (src1sel),
		.we_rf     (we_rf),
		.we_mem    (we_mem),
		.re_mem    (re_mem),
		.wb_sel    (wb_sel),
		.hlt       (hlt),
		.j_ctrl    (j_ctrl),
		.j_pc      (j_pc)
	);

endmodule

// File: sim/clk_gen.sv
// Clock and power-on reset for the decode stage testbench
// Period 10, reset low over the first two rising edges
module clk_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Released on a falling edge, clear of the sampling edge
	initial begin
		arst_n = 1'b0;
		#20;
		arst_n = 1'b1;
	end

endmodule

// File: sim/id_stage_tb.sv
// Random testbench for the decode stage with a cycle model of latch, decoder and registers
// Inputs change 1 unit after each rising edge, outputs are compared at the same point
module id_stage_tb
	import id_pkg::*;
();

	localparam int NUM_INSTR = 3000;
	localparam int TIMEOUT_CYC = NUM_INSTR * 2 + 100;

	// Flag bit positions in the expected flag vector
	localparam int F_WE_RF = 6;
	localparam int F_WE_MEM = 5;
	localparam int F_RE_MEM = 4;
	localparam int F_HLT = 3;
	localparam int F_JCTRL = 2;
	localparam int F_SRC1 = 1;
	localparam int F_WBSEL = 0;

	// Only these flags are cleared for a squashed or empty slot
	localparam logic [6:0] CTRL_MASK = 7'b1111100;

	typedef struct packed {
		logic valid;
		logic [6:0] flags;
		word_t p0;
		word_t p1;
		word_t j_pc;
		reg_addr_t dst;
		alu_func_t func;
		shamt_t shamt;
		imm8_t imm;
		logic chk_dst;
		logic chk_func;
		logic chk_shamt;
		logic chk_imm;
	} expect_t;

	logic clk;
	logic arst_n;
	logic in_valid;
	instr_t instr;
	word_t pc;
	logic wb_we;
	reg_addr_t wb_addr;
	word_t wb_data;
	logic out_valid;
	word_t p0;
	word_t p1;
	shamt_t shamt;
	alu_func_t func;
	imm8_t imm8;
	reg_addr_t dst_addr;
	logic src1sel;
	logic we_rf;
	logic we_mem;
	logic re_mem;
	logic wb_sel;
	logic hlt;
	logic j_ctrl;
	word_t j_pc;

	// Model state, mirrors the latch entry and register contents
	word_t model_regs [16];
	logic lat_live;
	instr_t lat_instr;
	word_t lat_pc;
	expect_t exp_q [$];

	integer seed;
	int value_errs;
	int valid_errs;
	int sent;
	int drain;
	word_t pc_cnt;

	clk_gen u_clk (
		.clk    (clk),
		.arst_n (arst_n)
	);

	id_stage_top UUT (
		.clk (clk), .arst_n (arst_n), .in_valid (in_valid), .instr (instr), .pc (pc),
		.wb_we (wb_we), .wb_addr (wb_addr), .wb_data (wb_data), .out_valid (out_valid),
		.p0 (p0), .p1 (p1), .shamt (shamt), .func (func), .imm8 (imm8),
		.dst_addr (dst_addr), .src1sel (src1sel), .we_rf (we_rf), .we_mem (we_mem),
		.re_mem (re_mem), .wb_sel (wb_sel), .hlt (hlt), .j_ctrl (j_ctrl), .j_pc (j_pc)
	);

	task automatic report_mismatch(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		value_errs++;
		$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp)
			report_mismatch(what, got, exp);
	endtask

	task automatic check_func(input alu_func_t got, input alu_func_t exp);
		if (got !== exp)
			report_mismatch("func", got, exp);
	endtask

	task automatic check_shamt(input shamt_t got, input shamt_t exp);
		if (got !== exp)
			report_mismatch("shamt", got, exp);
	endtask

	task automatic check_imm(input imm8_t got, input imm8_t exp);
		if (got !== exp)
			report_mismatch("imm8", got, exp);
	endtask

	// Flags as {we_rf, we_mem, re_mem, hlt, j_ctrl, src1sel, wb_sel}
	task automatic check_ctrl(input logic [6:0] got, input logic [6:0] exp,
		input logic [6:0] mask);
		if ((got & mask) !== (exp & mask))
			report_mismatch("control flags", got & mask, exp & mask);
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp) begin
			valid_errs++;
			if (exp)
				$display("FAIL %0t: out_valid missing for a live instruction", $time);
			else
				$display("FAIL %0t: out_valid high with nothing in flight", $time);
		end
	endtask

	// Register read as seen during the decode cycle, write-back bypasses
	function automatic word_t model_read(input reg_addr_t addr);
		word_t val;
		if (addr == 4'd0)
			val = '0;
		else if (wb_we && addr == wb_addr)
			val = wb_data;
		else
			val = model_regs[addr];
		return val;
	endfunction

	// Expected outputs for the entry live this cycle
	function automatic expect_t predict(input logic lv, input instr_t ins, input word_t ipc);
		expect_t e;
		logic [3:0] op;
		reg_addr_t f_rd;
		reg_addr_t f_rs;
		reg_addr_t f_rt;
		op = ins[15:12];
		f_rd = ins[11:8];
		f_rs = ins[7:4];
		f_rt = ins[3:0];
		e = '0;
		e.valid = lv;
		e.dst = f_rd;
		e.func = op[2:0];
		e.shamt = ins[3:0];
		e.imm = ins[7:0];
		if (lv) begin
			case (op)
				OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
					e.p0 = model_read(f_rs);
					e.p1 = model_read(f_rt);
					e.flags[F_WE_RF] = 1'b1;
					e.chk_dst = 1'b1;
					e.chk_func = 1'b1;
				end
				OP_SLL, OP_SRL, OP_SRA: begin
					e.p0 = model_read(f_rs);
					e.flags[F_WE_RF] = 1'b1;
					e.flags[F_SRC1] = 1'b1;
					e.chk_dst = 1'b1;
					e.chk_func = 1'b1;
					e.chk_shamt = 1'b1;
				end
				OP_LW: begin
					e.p0 = model_read(f_rs);
					e.flags[F_WE_RF] = 1'b1;
					e.flags[F_RE_MEM] = 1'b1;
					e.flags[F_WBSEL] = 1'b1;
					e.chk_dst = 1'b1;
				end
				OP_SW: begin
					// Base in rs, store data from rd
					e.p0 = model_read(f_rs);
					e.p1 = model_read(f_rd);
					e.flags[F_WE_MEM] = 1'b1;
				end
				OP_LHB: begin
					e.p0 = model_read(f_rd);
					e.flags[F_WE_RF] = 1'b1;
					e.chk_dst = 1'b1;
					e.chk_imm = 1'b1;
				end
				OP_LLB: begin
					e.flags[F_WE_RF] = 1'b1;
					e.chk_dst = 1'b1;
					e.chk_imm = 1'b1;
				end
				OP_JAL: begin
					// Target is pc + 1 plus the sign-extended 12-bit offset
					e.j_pc = ipc + 16'd1 + {{4{ins[11]}}, ins[11:0]};
					e.flags[F_JCTRL] = 1'b1;
					e.dst = LINK_REG;
					e.chk_dst = 1'b1;
				end
				OP_JR: begin
					e.p0 = model_read(f_rs);
					e.j_pc = e.p0;
					e.flags[F_JCTRL] = 1'b1;
				end
				OP_HLT: e.flags[F_HLT] = 1'b1;
				default: begin
					// Branch and nop, nothing enabled
				end
			endcase
		end
		return e;
	endfunction

	task automatic compare_outputs();
		expect_t e;
		logic [6:0] got_f;
		e = exp_q.pop_front();
		got_f = {we_rf, we_mem, re_mem, hlt, j_ctrl, src1sel, wb_sel};
		check_valid(out_valid, e.valid);
		if (e.valid && out_valid) begin
			check_ctrl(got_f, e.flags, 7'h7f);
			check_word("p0", p0, e.p0);
			check_word("p1", p1, e.p1);
			check_word("j_pc", j_pc, e.j_pc);
			if (e.chk_dst)
				check_addr("dst_addr", dst_addr, e.dst);
			if (e.chk_func)
				check_func(func, e.func);
			if (e.chk_shamt)
				check_shamt(shamt, e.shamt);
			if (e.chk_imm)
				check_imm(imm8, e.imm);
		end else begin
			check_ctrl(got_f, e.flags, CTRL_MASK);
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		logic [31:0] r2;
		logic [3:0] op;
		r = $random(seed);
		r2 = $random(seed);
		// Roughly one jal and one jr in every five
		op = r[11:8];
		if (r[14:12] == 3'd0)
			op = OP_JAL;
		else if (r[14:12] == 3'd1)
			op = OP_JR;
		in_valid = (sent < NUM_INSTR) && (r[6:0] < 7'd90);
		instr = {op, r2[11:0]};
		pc = pc_cnt;
		if (in_valid) begin
			pc_cnt = pc_cnt + 16'd1;
			sent++;
		end else if (sent >= NUM_INSTR) begin
			drain++;
		end
		wb_we = r[20];
		wb_addr = r[24:21];
		wb_data = r2[31:16];
	endtask

	// Write-back first, then the jal link write so R15 goes to the link
	task automatic step_model();
		expect_t e;
		e = predict(lat_live, lat_instr, lat_pc);
		exp_q.push_back(e);
		if (wb_we)
			model_regs[wb_addr] = wb_data;
		if (lat_live && lat_instr[15:12] == OP_JAL)
			model_regs[LINK_REG] = lat_pc + 16'd1;
		lat_live = in_valid & ~e.flags[F_JCTRL];
		if (in_valid) begin
			lat_instr = instr;
			lat_pc = pc;
		end
	endtask

	initial begin
		seed = 32'h7d26;
		in_valid = 1'b0;
		instr = '0;
		pc = '0;
		wb_we = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		value_errs = 0;
		valid_errs = 0;
		sent = 0;
		drain = 0;
		pc_cnt = 16'h0100;
		lat_live = 1'b0;
		lat_instr = '0;
		lat_pc = '0;
		for (int i = 0; i < 16; i++)
			model_regs[i] = '0;
		@(posedge arst_n);
		#1;
		// Control outputs straight out of reset
		check_valid(out_valid, 1'b0);
		check_ctrl({we_rf, we_mem, re_mem, hlt, j_ctrl, src1sel, wb_sel}, '0, CTRL_MASK);
		exp_q.push_back('0);
		while (sent < NUM_INSTR || drain < 3) begin
			@(posedge clk);
			#1;
			compare_outputs();
			drive_inputs();
			step_model();
		end
		$display("Errors: %0d value, %0d handshake", value_errs, valid_errs);
		if (value_errs == 0 && valid_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Watchdog, twice the strobe count in cycles plus slack
	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk);
		$display("Run timed out after %0d cycles before all instructions were checked",
			TIMEOUT_CYC);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: vlog.f
common/id_pkg.sv
common/dec_if.sv
common/rd_if.sv
hw/instr_latch.sv
hw/decode/instr_decode.sv
hw/decode/reg_file.sv
hw/id_out_reg.sv
hw/id_stage_top.sv
sim/clk_gen.sv
sim/id_stage_tb.sv
